// File: common/flash_pkg.sv
// flash geometry types, spi opcodes and status register bit positions
`default_nettype none

package flash_pkg;

	// ----------------------------------------------------------
	// geometry
	// ----------------------------------------------------------
	typedef logic [23:0] flash_addr_t;  // byte address inside the flash
	typedef logic [13:0] page_count_t;  // number of 256 byte pages in an image
	typedef logic [7:0]  flash_byte_t;  // one data byte on the wire

	localparam int unsigned SECTOR_BYTES = 65536;  // 64 KiB erase granule
	localparam int unsigned PAGE_BYTES   = 256;    // largest page program burst

	// ----------------------------------------------------------
	// spi command set
	// ----------------------------------------------------------
	localparam flash_byte_t OP_WREN = 8'h06;  // set write enable latch
	localparam flash_byte_t OP_SE   = 8'hD8;  // 64 KiB sector erase
	localparam flash_byte_t OP_PP   = 8'h02;  // page program
	localparam flash_byte_t OP_RDSR = 8'h05;  // read status register

	// status register layout
	// only the write-in-progress flag matters here, the rest is ignored
	localparam int unsigned WIP_BIT = 0;

endpackage

`default_nettype wire

// File: common/update_pkg.sv
// controller state encoding, flash operation codes, command struct and fifo count type
`default_nettype none

package update_pkg;

	// operations the engine knows how to run
	typedef enum logic [0:0] {
		FOP_ERASE   = 1'b0,  // wren + sector erase + status poll
		FOP_PROGRAM = 1'b1   // wren + page program of 256 fifo bytes + status poll
	} flash_op_e;

	// one request from the controller to the engine, 25 bits
	typedef struct packed {
		flash_op_e              op;
		flash_pkg::flash_addr_t addr;  // sector or page base
	} flash_cmd_t;

	// update sequencer states
	typedef enum logic [3:0] {
		ST_IDLE,           // wait for erase request or a full page of data
		ST_ERASE_ISSUE,    // hand one sector erase to the engine
		ST_ERASE_WAIT,     // erase in flight
		ST_ERASE_DONE,     // erase_done up, waiting for its ack
		ST_WAIT_DONE_ACK,  // ack and request must drop before idle
		ST_FILL,           // wait for 256 bytes, or raise the final send_more
		ST_PROG_WAIT,      // page program in flight
		ST_FINAL_ACK,      // last send_more up
		ST_RECONFIG        // count down then pull nconfig
	} ctrl_state_e;

	typedef logic [9:0] fifo_used_t;  // 0..512 bytes buffered

endpackage

`default_nettype wire

// File: design/remote_update_top.sv
// remote update top: receive fifo, update sequencer and spi flash engine
`timescale 1ns/10ps
`default_nettype none

module remote_update_top
	import flash_pkg::*, update_pkg::*;
#(
	parameter int unsigned ERASE_SECTORS  = 32,
	parameter int unsigned RECONFIG_DELAY = 25000000
) (
	input  wire              clock,
	input  wire              arst_n,
	input  wire flash_byte_t rx_data,         // firmware byte from the network
	input  wire              rx_wr,
	input  wire              erase,
	output logic             erase_ack,
	output logic             erase_done,
	input  wire              erase_done_ack,
	output logic             send_more,
	input  wire              send_more_ack,
	input  wire page_count_t num_blocks,      // image length in pages
	output logic             nconfig,
	output logic             spi_sclk,
	output logic             spi_cs_n,
	output logic             spi_mosi,
	input  wire              spi_miso
);

	flash_byte_t fifo_rd_data;
	fifo_used_t  fifo_used;
	logic        byte_take;
	flash_cmd_t  cmd;
	logic        cmd_valid;
	logic        flash_busy;

	rx_byte_fifo rx_byte_fifo_inst (
		.clock(clock), .arst_n(arst_n), .wr_data(rx_data), .wr(rx_wr),
		.rd_data(fifo_rd_data), .take(byte_take), .used(fifo_used)
	);

	flash_update_ctrl #(
		.ERASE_SECTORS(ERASE_SECTORS), .RECONFIG_DELAY(RECONFIG_DELAY)
	) flash_update_ctrl_inst (
		.clock(clock), .arst_n(arst_n), .erase(erase), .erase_done_ack(erase_done_ack),
		.send_more_ack(send_more_ack), .num_blocks(num_blocks), .fifo_used(fifo_used),
		.flash_busy(flash_busy), .erase_ack(erase_ack), .erase_done(erase_done),
		.send_more(send_more), .nconfig(nconfig), .cmd(cmd), .cmd_valid(cmd_valid)
	);

	spi_flash_engine spi_flash_engine_inst (
		.clock(clock), .arst_n(arst_n), .cmd(cmd), .cmd_valid(cmd_valid),
		.flash_busy(flash_busy), .fifo_data(fifo_rd_data), .byte_take(byte_take),
		.spi_sclk(spi_sclk), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
	);

endmodule

`default_nettype wire

// File: design/rx_byte_fifo.sv
// show-ahead 512 byte receive fifo with fill count and overflow/underflow checks
`timescale 1ns/10ps
`default_nettype none

module rx_byte_fifo
	import flash_pkg::*, update_pkg::*;
(
	input  wire              clock,
	input  wire              arst_n,
	input  wire flash_byte_t wr_data,  // byte from the network side
	input  wire              wr,       // one strobe per byte
	output flash_byte_t      rd_data,  // head of the queue, always valid when used != 0
	input  wire              take,     // pop the head
	output fifo_used_t       used
);

	localparam int DEPTH = 512;

	flash_byte_t mem [DEPTH];
	logic [8:0]  wr_ptr;  // wraps naturally at 512
	logic [8:0]  rd_ptr;
	logic        full;
	logic        empty;
	logic        do_wr;
	logic        do_rd;

	assign full  = (used == fifo_used_t'(DEPTH));
	assign empty = (used == '0);
	assign do_wr = wr && !full;  // writes to a full buffer are lost
	assign do_rd = take && !empty;

	assign rd_data = mem[rd_ptr];  // show-ahead, no read latency

	always_ff @(posedge clock) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 9'd1;
			if (do_rd)
				rd_ptr <= rd_ptr + 9'd1;
			case ({do_wr, do_rd})
				2'b10:   used <= used + fifo_used_t'(1);
				2'b01:   used <= used - fifo_used_t'(1);
				default: used <= used;  // both or neither, count unchanged
			endcase
		end
	end

	// host sent more than the buffer holds
	a_no_overflow: assert property (@(posedge clock) disable iff (!arst_n) wr |-> !full)
		else $error("rx fifo overflow, byte dropped");

	// engine popped before a full page was buffered
	a_no_underflow: assert property (@(posedge clock) disable iff (!arst_n) take |-> !empty)
		else $error("rx fifo underflow");

endmodule

`default_nettype wire

// File: flash_ctrl/flash_update_ctrl.sv
// flash update sequencer: sector erase loop, page program loop and delayed reconfiguration
`timescale 1ns/10ps
`default_nettype none

module flash_update_ctrl
	import flash_pkg::*, update_pkg::*;
#(
	parameter int unsigned ERASE_SECTORS  = 32,       // sectors cleared from address 0
	parameter int unsigned RECONFIG_DELAY = 25000000  // cycles before nconfig
) (
	input  wire              clock,
	input  wire              arst_n,
	input  wire              erase,
	input  wire              erase_done_ack,
	input  wire              send_more_ack,
	input  wire page_count_t num_blocks,
	input  wire fifo_used_t  fifo_used,
	input  wire              flash_busy,
	output logic             erase_ack,
	output logic             erase_done,
	output logic             send_more,
	output logic             nconfig,
	output flash_cmd_t       cmd,
	output logic             cmd_valid
);

	localparam int SEC_W = (ERASE_SECTORS > 1) ? $clog2(ERASE_SECTORS) : 1;
	localparam int DLY_W = $clog2(RECONFIG_DELAY + 1);
	localparam fifo_used_t PAGE_FILL = fifo_used_t'(PAGE_BYTES);

	ctrl_state_e      state;
	flash_addr_t      addr;        // current sector or page base
	page_count_t      page;        // pages written so far
	logic [SEC_W-1:0] sector_cnt;
	logic [DLY_W-1:0] delay_cnt;
	logic             op_done;
	logic             page_ready;

	// busy only rises the cycle after cmd_valid, so mask that cycle
	assign op_done = !cmd_valid && !flash_busy;

	// back-pressure, a whole page buffered and the host has seen the last request
	assign page_ready = (fifo_used >= PAGE_FILL) && !send_more && !flash_busy;

	// command payload follows the wait state it was issued from
	always_comb begin
		cmd.op   = (state == ST_PROG_WAIT) ? FOP_PROGRAM : FOP_ERASE;
		cmd.addr = addr;
	end

	// ----------------------------------------------------------
	// sequencer
	// ----------------------------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ST_IDLE;
			addr       <= '0;
			page       <= '0;
			sector_cnt <= '0;
			delay_cnt  <= '0;
			erase_ack  <= 1'b0;
			erase_done <= 1'b0;
			send_more  <= 1'b0;
			nconfig    <= 1'b0;
			cmd_valid  <= 1'b0;
		end else begin
			cmd_valid <= 1'b0;  // single cycle pulse
			case (state)
				ST_IDLE: begin
					erase_ack  <= 1'b0;
					addr       <= '0;  // both erase and program start at the bottom
					page       <= '0;
					sector_cnt <= '0;
					if (erase) begin
						erase_ack <= 1'b1;  // tell the host we saw it
						state     <= ST_ERASE_ISSUE;
					end else if (fifo_used >= PAGE_FILL) begin
						state <= ST_FILL;
					end
				end
				ST_ERASE_ISSUE: begin
					if (!flash_busy) begin
						cmd_valid <= 1'b1;
						state     <= ST_ERASE_WAIT;
					end
				end
				ST_ERASE_WAIT: begin
					if (op_done) begin
						if (sector_cnt == SEC_W'(ERASE_SECTORS - 1)) begin
							erase_done <= 1'b1;  // all sectors clear
							state      <= ST_ERASE_DONE;
						end else begin
							sector_cnt <= sector_cnt + 1'b1;
							addr       <= addr + flash_addr_t'(SECTOR_BYTES);
							state      <= ST_ERASE_ISSUE;
						end
					end
				end
				ST_ERASE_DONE: begin
					if (erase_done_ack) begin
						erase_done <= 1'b0;
						state      <= ST_WAIT_DONE_ACK;
					end
				end
				// a held erase level must not start a second erase pass
				ST_WAIT_DONE_ACK: begin
					if (!erase_done_ack && !erase)
						state <= ST_IDLE;
				end
				ST_FILL: begin
					if (send_more_ack)
						send_more <= 1'b0;  // host has the page request
					if (page == num_blocks) begin
						// image complete, one more request tells the host we are done
						if (!send_more && !send_more_ack) begin
							send_more <= 1'b1;
							state     <= ST_FINAL_ACK;
						end
					end else if (page_ready) begin
						cmd_valid <= 1'b1;
						state     <= ST_PROG_WAIT;
					end
				end
				ST_PROG_WAIT: begin
					if (op_done) begin
						addr      <= addr + flash_addr_t'(PAGE_BYTES);  // next page boundary
						page      <= page + 1'b1;
						send_more <= 1'b1;  // ask for the next 256 bytes
						state     <= ST_FILL;
					end
				end
				ST_FINAL_ACK: begin
					if (send_more_ack) begin
						send_more <= 1'b0;
						delay_cnt <= '0;
						state     <= ST_RECONFIG;
					end
				end
				ST_RECONFIG: begin
					if (delay_cnt == DLY_W'(RECONFIG_DELAY)) begin
						if (!flash_busy)
							nconfig <= 1'b1;  // reload the fpga, held until reset
					end else begin
						delay_cnt <= delay_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// engine accepts a command only when idle
	a_cmd_not_busy: assert property (@(posedge clock) disable iff (!arst_n)
		cmd_valid |-> !flash_busy)
		else $error("command issued while flash engine busy");

	// reconfiguration is terminal
	a_nconfig_sticky: assert property (@(posedge clock) disable iff (!arst_n)
		nconfig |=> nconfig && state == ST_RECONFIG)
		else $error("nconfig dropped after being set");

endmodule

`default_nettype wire

// File: flash_ctrl/spi_flash_engine.sv
// spi mode 0 flash command engine: wren, erase or page program, then status polling
`timescale 1ns/10ps
`default_nettype none

module spi_flash_engine
	import flash_pkg::*, update_pkg::*;
(
	input  wire              clock,
	input  wire              arst_n,
	input  wire flash_cmd_t  cmd,
	input  wire              cmd_valid,
	output logic             flash_busy,
	input  wire flash_byte_t fifo_data,
	output logic             byte_take,  // pops the byte just loaded into the shifter
	output logic             spi_sclk,
	output logic             spi_cs_n,
	output logic             spi_mosi,
	input  wire              spi_miso
);

	typedef enum logic [1:0] {PH_IDLE, PH_SELECT, PH_SHIFT} phase_e;
	typedef enum logic [1:0] {FR_WREN, FR_CMD, FR_RDSR} frame_e;  // cs low periods

	localparam logic [8:0] LAST_SE = 9'd3;                 // opcode + 3 address bytes
	localparam logic [8:0] LAST_PP = 9'(3 + PAGE_BYTES);  // ... plus one page of data

	phase_e      phase;
	frame_e      frame;
	flash_cmd_t  cur;         // command being run
	flash_byte_t shift_out;
	flash_byte_t shift_in;
	flash_byte_t rx_byte;
	flash_byte_t first_byte;
	flash_byte_t next_byte;
	logic [2:0]  bit_cnt;
	logic [8:0]  byte_cnt;    // byte in flight within the frame
	logic        last_byte;
	logic        take_next;

	assign spi_mosi = shift_out[7];                // msb first, no bit reversal
	assign rx_byte  = {shift_in[6:0], spi_miso};  // byte complete at the 8th falling edge

	always_comb begin
		case (frame)
			FR_WREN: first_byte = OP_WREN;
			FR_RDSR: first_byte = OP_RDSR;
			default: first_byte = (cur.op == FOP_ERASE) ? OP_SE : OP_PP;
		endcase
		case (byte_cnt)
			9'd0:    next_byte = cur.addr[23:16];
			9'd1:    next_byte = cur.addr[15:8];
			9'd2:    next_byte = cur.addr[7:0];
			default: next_byte = fifo_data;  // page data straight from the fifo head
		endcase
		if (frame == FR_RDSR)
			next_byte = 8'h00;  // dummy while status shifts in
		case (frame)
			FR_WREN: last_byte = 1'b1;
			FR_RDSR: last_byte = (byte_cnt == 9'd1);
			default: last_byte = (byte_cnt == ((cur.op == FOP_ERASE) ? LAST_SE : LAST_PP));
		endcase
		take_next = (frame == FR_CMD) && (byte_cnt >= 9'd3) && !last_byte;
	end

	always_ff @(posedge clock) begin
		if (phase == PH_IDLE && cmd_valid)
			cur <= cmd;
		if (phase == PH_SHIFT && spi_sclk)
			shift_in <= rx_byte;
	end

	// ----------------------------------------------------------
	// bit engine, sclk = clock / 2
	// ----------------------------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			phase      <= PH_IDLE;
			frame      <= FR_WREN;
			flash_busy <= 1'b0;
			byte_take  <= 1'b0;
			spi_sclk   <= 1'b0;
			spi_cs_n   <= 1'b1;
			shift_out  <= '0;
			bit_cnt    <= '0;
			byte_cnt   <= '0;
		end else begin
			byte_take <= 1'b0;
			case (phase)
				PH_IDLE: begin
					if (cmd_valid) begin
						flash_busy <= 1'b1;
						frame      <= FR_WREN;  // every operation opens with write enable
						phase      <= PH_SELECT;
					end
				end
				PH_SELECT: begin
					spi_cs_n  <= 1'b0;
					shift_out <= first_byte;
					bit_cnt   <= '0;
					byte_cnt  <= '0;
					phase     <= PH_SHIFT;
				end
				PH_SHIFT: begin
					spi_sclk <= ~spi_sclk;  // flash samples on the rising edge
					if (spi_sclk) begin
						if (bit_cnt != 3'd7) begin
							bit_cnt   <= bit_cnt + 3'd1;
							shift_out <= {shift_out[6:0], 1'b0};
						end else begin
							bit_cnt   <= '0;
							byte_cnt  <= byte_cnt + 9'd1;
							shift_out <= next_byte;
							byte_take <= take_next;
							if (last_byte) begin
								spi_cs_n <= 1'b1;  // end of frame
								phase    <= PH_SELECT;
								case (frame)
									FR_WREN: frame <= FR_CMD;
									FR_CMD:  frame <= FR_RDSR;
									default: begin
										if (!rx_byte[WIP_BIT]) begin
											flash_busy <= 1'b0;  // flash idle again
											phase      <= PH_IDLE;
										end
									end
								endcase
							end
						end
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	a_cs_idle: assert property (@(posedge clock) disable iff (!arst_n) !flash_busy |-> spi_cs_n)
		else $error("chip select active while engine idle");

endmodule

`default_nettype wire

// File: sources.f
common/flash_pkg.sv
common/update_pkg.sv
design/rx_byte_fifo.sv
flash_ctrl/flash_update_ctrl.sv
flash_ctrl/spi_flash_engine.sv
design/remote_update_top.sv
test/spi_flash_model.sv
test/tb_remote_update.sv

// File: test/spi_flash_model.sv
// behavioral spi flash: 128 KiB array, write enable latch, busy countdown and erase log
`timescale 1ns/10ps
`default_nettype none

module spi_flash_model
	import flash_pkg::*;
(
	input  wire  spi_sclk,
	input  wire  spi_cs_n,
	input  wire  spi_mosi,
	output logic spi_miso
);

	localparam int MEM_BYTES = 131072;  // two sectors

	flash_byte_t mem [MEM_BYTES];
	flash_byte_t frame_buf [PAGE_BYTES + 4];  // opcode, 3 address bytes, page data
	flash_byte_t shreg;
	flash_byte_t status;
	flash_addr_t erase_log [8];      // sector addresses in arrival order
	flash_addr_t base;
	logic [16:0] idx;
	int          erase_count;
	int          pp_count;           // page program opcodes seen
	int          bit_cnt;            // bits since chip select fell
	int          nbytes;
	int          busy_polls;         // status reads left with wip set
	logic        wel;                // write enable latch
	logic        wren_err;           // erase or program without wel

	initial begin
		for (int i = 0; i < MEM_BYTES; i++)
			mem[i] = 8'h00;
		erase_count = 0;
		pp_count    = 0;
		bit_cnt     = 0;
		busy_polls  = 0;
		wel         = 1'b0;
		wren_err    = 1'b0;
		status      = '0;
		spi_miso    = 1'b0;
	end

	always @(negedge spi_cs_n) bit_cnt = 0;

	// mode 0, mosi sampled on the rising edge
	always @(posedge spi_sclk) begin
		if (!spi_cs_n) begin
			shreg   = {shreg[6:0], spi_mosi};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt % 8 == 0 && bit_cnt <= 8 * (PAGE_BYTES + 4))
				frame_buf[bit_cnt / 8 - 1] = shreg;
			if (bit_cnt == 8 && shreg == OP_RDSR) begin
				status          = '0;
				status[WIP_BIT] = (busy_polls != 0);
				if (busy_polls != 0)
					busy_polls = busy_polls - 1;  // one poll consumed
			end
			if (bit_cnt == 8 && shreg == OP_PP)
				pp_count = pp_count + 1;
		end
	end

	// status byte goes out msb first right after the opcode
	always @(negedge spi_sclk) begin
		if (!spi_cs_n && bit_cnt >= 8 && bit_cnt < 16)
			spi_miso <= status[15 - bit_cnt];
	end

	// ----------------------------------------------------------
	// command execution at the end of each frame
	// ----------------------------------------------------------
	always @(posedge spi_cs_n) begin
		nbytes = bit_cnt / 8;
		base   = {frame_buf[1], frame_buf[2], frame_buf[3]};
		case (frame_buf[0])
			OP_WREN: wel = 1'b1;
			OP_SE: begin
				if (!wel) begin
					wren_err = 1'b1;
				end else begin
					if (erase_count < 8)
						erase_log[erase_count] = base;
					erase_count = erase_count + 1;
					for (int i = 0; i < SECTOR_BYTES; i++) begin
						idx      = {base[16], 16'h0000} + i[16:0];  // sector aligned
						mem[idx] = 8'hFF;
					end
					busy_polls = 30;
				end
				wel = 1'b0;
			end
			OP_PP: begin
				if (!wel) begin
					wren_err = 1'b1;
				end else begin
					for (int i = 0; i < nbytes - 4; i++) begin
						idx      = {base[16:8], base[7:0] + i[7:0]};  // wraps inside the page
						mem[idx] = mem[idx] & frame_buf[4 + i];
					end
					busy_polls = 10;
				end
				wel = 1'b0;
			end
			default: ;  // status reads change nothing
		endcase
	end

endmodule

`default_nettype wire

// File: test/tb_remote_update.sv
// testbench for remote_update_top with erase, table driven page program, request and reconfiguration tests
`timescale 1ns/10ps
`default_nettype none

module tb_remote_update
	import flash_pkg::*;
();

	localparam int ERASES         = 2;
	localparam int PAGES          = 4;
	localparam int DELAY          = 200;
	localparam int MEM_BYTES      = 131072;
	localparam int TIMEOUT_CYCLES = (ERASES * 200 + PAGES * 5000 + DELAY) * 2;

	typedef struct packed {
		logic [8:0] chunk;   // bytes written back to back
		logic [7:0] gap;     // idle cycles between chunks
		logic [3:0] exp_sm;  // send_more pulses counted once the page is acked
	} page_row_t;

	logic        clock;
	logic        arst_n;
	flash_byte_t rx_data;
	logic        rx_wr;
	logic        erase;
	logic        erase_done_ack;
	logic        send_more_ack;
	page_count_t num_blocks;
	wire         erase_ack;
	wire         erase_done;
	wire         send_more;
	wire         nconfig;
	wire         spi_sclk;
	wire         spi_cs_n;
	wire         spi_mosi;
	wire         spi_miso;

	page_row_t   rows [PAGES];
	flash_byte_t expected [PAGES * PAGE_BYTES];  // image bytes in flash order
	integer      seed;
	integer      rnd;
	int          cycle      = 0;
	int          err_count  = 0;
	int          err_mark;
	int          sm_rises   = 0;
	logic        sm_prev    = 1'b0;
	int          bytes_sent = 0;
	int          bp_errs    = 0;
	int          ack_cycle  = 0;

	remote_update_top #(
		.ERASE_SECTORS(ERASES), .RECONFIG_DELAY(DELAY)
	) remote_update_top_inst (
		.clock(clock), .arst_n(arst_n), .rx_data(rx_data), .rx_wr(rx_wr), .erase(erase),
		.erase_ack(erase_ack), .erase_done(erase_done), .erase_done_ack(erase_done_ack),
		.send_more(send_more), .send_more_ack(send_more_ack), .num_blocks(num_blocks),
		.nconfig(nconfig), .spi_sclk(spi_sclk), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi),
		.spi_miso(spi_miso)
	);

	spi_flash_model flash_model_inst (
		.spi_sclk(spi_sclk), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;  // 50 MHz
	end

	always @(posedge clock) cycle <= cycle + 1;

	initial begin
		wait (cycle >= TIMEOUT_CYCLES);
		$display("timeout after %0d cycles, the DUT never reached the end of the update", cycle);
		$display("Errors found");
		$finish;
	end

	// request pulses counted mid cycle
	always @(negedge clock) begin
		if (send_more && !sm_prev)
			sm_rises <= sm_rises + 1;
		sm_prev <= send_more;
	end

	// a page program opcode must find the whole page already sent
	always @(flash_model_inst.pp_count) begin
		if (bytes_sent < flash_model_inst.pp_count * PAGE_BYTES) begin
			$display("page program %0d started at %0t with only %0d bytes sent",
				flash_model_inst.pp_count, $time, bytes_sent);
			bp_errs = bp_errs + 1;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAILED t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
		err_count++;
	endtask

	task automatic report_problem(input string msg);
		$display("at %0t: %s", $time, msg);
		err_count++;
	endtask

	// ----------------------------------------------------------
	// host side helpers
	// ----------------------------------------------------------
	task automatic send_page(input int p);
		int idx;
		int k;
		idx = 0;
		while (idx < PAGE_BYTES) begin
			for (k = 0; k < rows[p].chunk && idx < PAGE_BYTES; k++) begin
				@(negedge clock);
				rx_data = expected[p * PAGE_BYTES + idx];
				rx_wr   = 1'b1;
				idx++;
				bytes_sent++;
			end
			@(negedge clock);
			rx_wr = 1'b0;
			repeat (rows[p].gap) @(negedge clock);
		end
	endtask

	task automatic ack_send_more();
		while (!send_more) @(negedge clock);
		repeat (3) @(negedge clock);
		if (send_more !== 1'b1)
			report_mismatch("send_more", send_more, 1);  // must hold until acked
		send_more_ack = 1'b1;
		ack_cycle     = cycle;  // the last one starts the reconfig delay
		while (send_more) @(negedge clock);
		send_more_ack = 1'b0;
	endtask

	initial begin
		int mism;
		arst_n         = 1'b0;
		rx_data        = '0;
		rx_wr          = 1'b0;
		erase          = 1'b0;
		erase_done_ack = 1'b0;
		send_more_ack  = 1'b0;
		num_blocks     = page_count_t'(PAGES);
		seed           = 47775;
		rows[0]        = '{9'd1, 8'd2, 4'd1};    // slow single bytes
		rows[1]        = '{9'd16, 8'd5, 4'd2};
		rows[2]        = '{9'd256, 8'd0, 4'd3};  // one burst
		rows[3]        = '{9'd7, 8'd11, 4'd4};
		for (int i = 0; i < PAGES * PAGE_BYTES; i++) begin
			rnd         = $random(seed);
			expected[i] = rnd[7:0];
		end
		repeat (4) @(negedge clock);
		arst_n = 1'b1;

		// erase of both sectors
		err_mark = err_count;
		repeat (2) @(negedge clock);
		if (erase_ack !== 1'b0)
			report_mismatch("erase_ack", erase_ack, 0);
		erase = 1'b1;
		while (!erase_ack) @(negedge clock);
		repeat (3) @(negedge clock);
		erase = 1'b0;
		while (!erase_done) @(negedge clock);
		repeat (3) @(negedge clock);
		if (erase_done !== 1'b1)
			report_mismatch("erase_done", erase_done, 1);  // must hold until acked
		erase_done_ack = 1'b1;
		while (erase_done) @(negedge clock);
		erase_done_ack = 1'b0;
		if (flash_model_inst.erase_count != ERASES)
			report_mismatch("erase_count", flash_model_inst.erase_count, ERASES);
		if (flash_model_inst.erase_log[0] !== 24'h000000)
			report_mismatch("erase_log[0]", flash_model_inst.erase_log[0], 24'h000000);
		if (flash_model_inst.erase_log[1] !== 24'h010000)
			report_mismatch("erase_log[1]", flash_model_inst.erase_log[1], 24'h010000);
		mism = 0;
		for (int i = 0; i < MEM_BYTES; i++)
			if (flash_model_inst.mem[i] !== 8'hFF)
				mism++;
		if (mism != 0)
			report_mismatch("unerased byte count", mism, 0);
		$display("erase test finished, %0d mismatches", err_count - err_mark);

		// one request per table page plus the closing one
		err_mark = err_count;
		for (int p = 0; p < PAGES; p++) begin
			send_page(p);
			ack_send_more();
			if (sm_rises != rows[p].exp_sm)
				report_mismatch("send_more pulses", sm_rises, rows[p].exp_sm);
		end
		ack_send_more();
		if (sm_rises != PAGES + 1)
			report_mismatch("send_more pulses", sm_rises, PAGES + 1);
		if (nconfig !== 1'b0)
			report_mismatch("nconfig", nconfig, 0);
		$display("page request test finished, %0d mismatches", err_count - err_mark);

		err_mark = err_count;
		for (int i = 0; i < MEM_BYTES; i++) begin
			if (i < PAGES * PAGE_BYTES) begin
				if (flash_model_inst.mem[i] !== expected[i])
					report_mismatch($sformatf("mem[%0h]", i), flash_model_inst.mem[i],
						expected[i]);
			end else if (flash_model_inst.mem[i] !== 8'hFF) begin
				report_mismatch($sformatf("mem[%0h]", i), flash_model_inst.mem[i], 8'hFF);
			end
		end
		$display("contents test finished, %0d mismatches", err_count - err_mark);

		err_mark  = err_count;
		err_count = err_count + bp_errs;
		if (flash_model_inst.pp_count != PAGES)
			report_mismatch("page programs", flash_model_inst.pp_count, PAGES);
		$display("back-pressure test finished, %0d mismatches", err_count - err_mark);

		err_mark = err_count;
		if (flash_model_inst.wren_err !== 1'b0)
			report_problem("flash got an erase or program without write enable");
		$display("write enable test finished, %0d mismatches", err_count - err_mark);

		// reconfiguration delay and nconfig hold
		err_mark = err_count;
		while (!nconfig) @(negedge clock);
		if (cycle - ack_cycle < DELAY)
			report_problem($sformatf("nconfig rose %0d cycles after the last ack",
				cycle - ack_cycle));
		repeat (50) begin
			@(negedge clock);
			if (nconfig !== 1'b1)
				report_mismatch("nconfig", nconfig, 1);
		end
		$display("reconfiguration test finished, %0d mismatches", err_count - err_mark);

		$display("tests run: 6, failed checks: %0d", err_count);
		if (err_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
